// ==== src/ring_pkg.sv ====
package ring_pkg;

  // Ring word and thread geometry
  parameter int RING_W      = 79;
  parameter int NUM_THREADS = 4;
  parameter int TID_W       = $clog2(NUM_THREADS);
  parameter int NODE_ID_W   = 6;

  // Width of the writeback register select
  parameter int RC_W        = 3;

  // Data lanes carried in one ring word
  parameter int DATA_W      = 32;
  parameter int MASK_W      = DATA_W / 8;

  // Packet control bits
  parameter int F_VLD       = 78;
  parameter int F_WR        = 77;

  // Set in an ack, clear in a retry and in every request
  parameter int F_ACK       = 76;

  // Requester id, node id in the upper bits and thread in the lower bits
  parameter int F_ID_HI     = 75;
  parameter int F_ID_LO     = 68;

  // Byte lane enables
  parameter int F_MASK_HI   = 67;
  parameter int F_MASK_LO   = 64;

  // Write data in a request, read data in a response
  parameter int F_DATA_HI   = 63;
  parameter int F_DATA_LO   = 32;

  // Byte address of the access
  parameter int F_ADDR_HI   = 31;
  parameter int F_ADDR_LO   = 0;

endpackage

// ==== src/ring_req_slots.sv ====
module ring_req_slots #(
  parameter logic [ring_pkg::NODE_ID_W-1:0] NODE_ID = '0
) (
  input  logic                                           CLK,
  input  logic                                           RST,
  input  logic [ring_pkg::TID_W-1:0]                     slice,
  input  logic                                           req_cs,
  input  logic                                           req_swap,
  input  logic                                           req_wr,
  input  logic [ring_pkg::DATA_W-1:0]                    req_addr,
  input  logic [ring_pkg::MASK_W-1:0]                    req_mask,
  input  logic [ring_pkg::DATA_W-1:0]                    req_wdata,
  input  logic [ring_pkg::RC_W-1:0]                      req_rc,
  input  logic [ring_pkg::NUM_THREADS-1:0]               ack_vec,
  output logic [ring_pkg::NUM_THREADS-1:0]               stall,
  output logic [ring_pkg::NUM_THREADS-1:0]               slot_pending,
  output logic [ring_pkg::NUM_THREADS-1:0]               slot_wr,
  output logic [ring_pkg::NUM_THREADS-1:0]               slot_swap,
  output logic [ring_pkg::NUM_THREADS*ring_pkg::DATA_W-1:0] slot_addr,
  output logic [ring_pkg::NUM_THREADS*ring_pkg::MASK_W-1:0] slot_mask,
  output logic [ring_pkg::NUM_THREADS*ring_pkg::DATA_W-1:0] slot_wdata,
  output logic [ring_pkg::NUM_THREADS*ring_pkg::RC_W-1:0]   slot_rc
);

  // The issue pipeline runs two slices ahead of the thread that owns the request
  localparam logic [ring_pkg::TID_W-1:0] ISSUE_OFS = 2;

  logic [ring_pkg::TID_W-1:0]       req_thread;
  logic [ring_pkg::NUM_THREADS-1:0] req_vec;
  logic [ring_pkg::NUM_THREADS-1:0] pending;

  // Wraps modulo the thread count
  assign req_thread = slice + ISSUE_OFS;

  always_comb
  begin
    req_vec = '0;
    if (req_cs)
      req_vec[req_thread] = 1'b1;
  end

  // A thread stays pending from capture until its ack has been registered
  always_ff @(posedge CLK or posedge RST)
  begin
    if (RST)
      pending <= '0;
    else
      pending <= (pending & ~ack_vec) | req_vec;
  end

  assign stall        = pending;
  assign slot_pending = pending;

  always_ff @(posedge CLK)
  begin
    for (int t = 0; t < ring_pkg::NUM_THREADS; t++)
    begin
      if (req_vec[t])
      begin
        // A swap goes out as a write, the swap flag only decides the writeback
        slot_wr[t]                                        <= req_wr | req_swap;
        slot_swap[t]                                      <= req_swap;
        slot_addr[t*ring_pkg::DATA_W +: ring_pkg::DATA_W]  <= req_addr;
        slot_mask[t*ring_pkg::MASK_W +: ring_pkg::MASK_W]  <= req_mask;
        slot_wdata[t*ring_pkg::DATA_W +: ring_pkg::DATA_W] <= req_wdata;
        slot_rc[t*ring_pkg::RC_W +: ring_pkg::RC_W]        <= req_rc;
      end
    end
  end

  // The issuer has to respect stall, a second request would overwrite a live slot
  a_no_issue_when_pending: assert property (
    @(posedge CLK) disable iff (RST)
    req_cs |-> !pending[req_thread]
  ) else $error("node %0d: request for pending thread %0d", NODE_ID, req_thread);

endmodule

// ==== src/ring_node_arb.sv ====
module ring_node_arb #(
  parameter logic [ring_pkg::NODE_ID_W-1:0] NODE_ID = '0
) (
  input  logic                                              CLK,
  input  logic                                              RST,
  input  logic [ring_pkg::RING_W-1:0]                       ring_in,
  input  logic [ring_pkg::NUM_THREADS-1:0]                  slot_pending,
  input  logic [ring_pkg::NUM_THREADS-1:0]                  slot_wr,
  input  logic [ring_pkg::NUM_THREADS*ring_pkg::DATA_W-1:0] slot_addr,
  input  logic [ring_pkg::NUM_THREADS*ring_pkg::MASK_W-1:0] slot_mask,
  input  logic [ring_pkg::NUM_THREADS*ring_pkg::DATA_W-1:0] slot_wdata,
  output logic [ring_pkg::RING_W-1:0]                       ring_out,
  output logic [ring_pkg::NUM_THREADS-1:0]                  ack_vec,
  output logic [ring_pkg::NUM_THREADS-1:0]                  retry_vec,
  output logic [ring_pkg::TID_W-1:0]                        rsp_thread,
  output logic [ring_pkg::DATA_W-1:0]                       rsp_data
);

  logic [ring_pkg::RING_W-1:0]      rin_q;
  logic [ring_pkg::NODE_ID_W-1:0]   rin_node;
  logic                             rin_own;
  logic                             rin_foreign;
  logic [ring_pkg::TID_W-1:0]       phase;
  logic [ring_pkg::NUM_THREADS-1:0] sent;
  logic [ring_pkg::NUM_THREADS-1:0] emit_vec;
  logic                             phase_req;
  logic [ring_pkg::RING_W-1:0]      req_word;

  always_ff @(posedge CLK or posedge RST)
  begin
    if (RST)
      rin_q <= '0;
    else
      rin_q <= ring_in;
  end

  assign rin_node    = rin_q[ring_pkg::F_ID_HI -: ring_pkg::NODE_ID_W];
  assign rin_own     = rin_q[ring_pkg::F_VLD] && (rin_node == NODE_ID);
  assign rin_foreign = rin_q[ring_pkg::F_VLD] && (rin_node != NODE_ID);
  assign rsp_thread  = rin_q[ring_pkg::F_ID_LO +: ring_pkg::TID_W];
  assign rsp_data    = rin_q[ring_pkg::F_DATA_HI:ring_pkg::F_DATA_LO];

  // Every packet carrying our id is a response, the ack bit tells ack from retry
  always_comb
  begin
    ack_vec   = '0;
    retry_vec = '0;
    if (rin_own)
    begin
      if (rin_q[ring_pkg::F_ACK])
        ack_vec[rsp_thread] = 1'b1;
      else
        retry_vec[rsp_thread] = 1'b1;
    end
  end

  // Only the slot owning the current phase may go out, and only when the slot is free
  always_comb
  begin
    phase_req       = slot_pending[phase] && !sent[phase] && !rin_foreign;
    emit_vec        = '0;
    emit_vec[phase] = phase_req;

    req_word                                           = '0;
    req_word[ring_pkg::F_VLD]                          = 1'b1;
    req_word[ring_pkg::F_WR]                           = slot_wr[phase];
    req_word[ring_pkg::F_ID_HI -: ring_pkg::NODE_ID_W] = NODE_ID;
    req_word[ring_pkg::F_ID_LO +: ring_pkg::TID_W]     = phase;
    req_word[ring_pkg::F_MASK_HI:ring_pkg::F_MASK_LO]  =
      slot_mask[phase*ring_pkg::MASK_W +: ring_pkg::MASK_W];
    req_word[ring_pkg::F_DATA_HI:ring_pkg::F_DATA_LO]  =
      slot_wdata[phase*ring_pkg::DATA_W +: ring_pkg::DATA_W];
    req_word[ring_pkg::F_ADDR_HI:ring_pkg::F_ADDR_LO]  =
      slot_addr[phase*ring_pkg::DATA_W +: ring_pkg::DATA_W];
  end

  // A retry drops the sent mark so the slot goes out again in its next phase
  always_ff @(posedge CLK or posedge RST)
  begin
    if (RST)
      sent <= '0;
    else
      sent <= (sent & ~(ack_vec | retry_vec)) | emit_vec;
  end

  // Forwarding holds the rotation where it is
  always_ff @(posedge CLK or posedge RST)
  begin
    if (RST)
    begin
      phase    <= '0;
      ring_out <= '0;
    end
    else if (rin_foreign)
      ring_out <= rin_q;
    else
    begin
      phase    <= phase + 1'b1;
      ring_out <= phase_req ? req_word : '0;
    end
  end

  // Responses must belong to a request this node actually put on the ring
  a_ack_needs_sent: assert property (
    @(posedge CLK) disable iff (RST)
    (ack_vec & ~sent) == '0
  ) else $error("ack for thread %0d without an outstanding request", rsp_thread);

endmodule

// ==== src/load_format.sv ====
module load_format (
  input  logic                                              CLK,
  input  logic                                              RST,
  input  logic [ring_pkg::NUM_THREADS-1:0]                  ack_vec,
  input  logic [ring_pkg::TID_W-1:0]                        rsp_thread,
  input  logic [ring_pkg::DATA_W-1:0]                       rsp_data,
  input  logic [ring_pkg::NUM_THREADS-1:0]                  slot_wr,
  input  logic [ring_pkg::NUM_THREADS-1:0]                  slot_swap,
  input  logic [ring_pkg::NUM_THREADS*ring_pkg::MASK_W-1:0] slot_mask,
  input  logic [ring_pkg::NUM_THREADS*ring_pkg::RC_W-1:0]   slot_rc,
  output logic                                              load_vld,
  output logic [ring_pkg::TID_W-1:0]                        load_slice,
  output logic [ring_pkg::RC_W-1:0]                         load_sel,
  output logic [ring_pkg::DATA_W-1:0]                       load_data
);

  logic                        sel_returns;
  logic [ring_pkg::MASK_W-1:0] sel_mask;
  logic [ring_pkg::DATA_W-1:0] fmt_data;

  // Plain writes complete silently, reads and swaps write a register back
  assign sel_returns = slot_swap[rsp_thread] || !slot_wr[rsp_thread];
  assign sel_mask    = slot_mask[rsp_thread*ring_pkg::MASK_W +: ring_pkg::MASK_W];

  always_comb
  begin
    fmt_data = '0;
    case (sel_mask)
      4'b0001: fmt_data[7:0]  = rsp_data[7:0];
      4'b0010: fmt_data[7:0]  = rsp_data[15:8];
      4'b0100: fmt_data[7:0]  = rsp_data[23:16];
      4'b1000: fmt_data[7:0]  = rsp_data[31:24];
      4'b0011: fmt_data[15:0] = rsp_data[15:0];
      4'b1100: fmt_data[15:0] = rsp_data[31:16];
      default: fmt_data       = rsp_data;
    endcase
  end

  always_ff @(posedge CLK or posedge RST)
  begin
    if (RST)
      load_vld <= 1'b0;
    else
      load_vld <= (|ack_vec) && sel_returns;
  end

  // The slice tag is the thread number of the completed request
  always_ff @(posedge CLK)
  begin
    load_slice <= rsp_thread;
    load_sel   <= slot_rc[rsp_thread*ring_pkg::RC_W +: ring_pkg::RC_W];
    load_data  <= fmt_data;
  end

endmodule

// ==== src/ring_mem_node.sv ====
module ring_mem_node #(
  parameter int MEM_WORDS = 64
) (
  input  logic                        CLK,
  input  logic                        RST,
  input  logic [ring_pkg::RING_W-1:0] ring_in,
  output logic [ring_pkg::RING_W-1:0] ring_out
);

  localparam int IDX_W = $clog2(MEM_WORDS);

  logic [ring_pkg::DATA_W-1:0] mem [MEM_WORDS];
  logic [ring_pkg::RING_W-1:0] rin_q;
  logic [IDX_W-1:0]            mem_idx;
  logic                        is_req;
  logic                        busy;
  logic                        do_write;

  initial
  begin
    for (int i = 0; i < MEM_WORDS; i++)
      mem[i] = '0;
  end

  always_ff @(posedge CLK or posedge RST)
  begin
    if (RST)
      rin_q <= '0;
    else
      rin_q <= ring_in;
  end

  assign mem_idx  = IDX_W'(rin_q[ring_pkg::F_ADDR_HI:ring_pkg::F_ADDR_LO+2] % MEM_WORDS);
  assign is_req   = rin_q[ring_pkg::F_VLD] && !rin_q[ring_pkg::F_ACK];
  assign do_write = is_req && !busy && rin_q[ring_pkg::F_WR];

  // Writes and swaps both hand back the old word, the requester decides what to keep
  always_ff @(posedge CLK or posedge RST)
  begin
    if (RST)
    begin
      busy     <= 1'b0;
      ring_out <= '0;
    end
    else
    begin
      busy <= do_write;
      if (!rin_q[ring_pkg::F_VLD])
        ring_out <= '0;
      else if (!is_req || busy)
        // Responses travel on untouched, a request during busy returns as a retry
        ring_out <= rin_q;
      else
      begin
        ring_out                                            <= rin_q;
        ring_out[ring_pkg::F_ACK]                           <= 1'b1;
        ring_out[ring_pkg::F_DATA_HI:ring_pkg::F_DATA_LO]   <= mem[mem_idx];
      end
    end
  end

  always_ff @(posedge CLK)
  begin
    for (int b = 0; b < ring_pkg::MASK_W; b++)
    begin
      if (do_write && rin_q[ring_pkg::F_MASK_LO+b])
        mem[mem_idx][8*b +: 8] <= rin_q[ring_pkg::F_DATA_LO+8*b +: 8];
    end
  end

  // The core node consumes every response with its id, so none should come around
  a_no_rsp_loop: assert property (
    @(posedge CLK) disable iff (RST)
    rin_q[ring_pkg::F_VLD] |-> !rin_q[ring_pkg::F_ACK]
  ) else $error("response packet came back to the memory node");

endmodule

// ==== src/ring_subsys_top.sv ====
module ring_subsys_top #(
  parameter logic [ring_pkg::NODE_ID_W-1:0] NODE_ID   = '0,
  parameter int                             MEM_WORDS = 64
) (
  input  logic                             CLK,
  input  logic                             RST,
  input  logic [ring_pkg::TID_W-1:0]       slice,
  input  logic                             req_cs,
  input  logic                             req_swap,
  input  logic                             req_wr,
  input  logic [ring_pkg::DATA_W-1:0]      req_addr,
  input  logic [ring_pkg::MASK_W-1:0]      req_mask,
  input  logic [ring_pkg::DATA_W-1:0]      req_wdata,
  input  logic [ring_pkg::RC_W-1:0]        req_rc,
  output logic [ring_pkg::NUM_THREADS-1:0] stall,
  output logic                             load_vld,
  output logic [ring_pkg::TID_W-1:0]       load_slice,
  output logic [ring_pkg::RC_W-1:0]        load_sel,
  output logic [ring_pkg::DATA_W-1:0]      load_data
);

  logic [ring_pkg::NUM_THREADS-1:0]                  slot_pending;
  logic [ring_pkg::NUM_THREADS-1:0]                  slot_wr;
  logic [ring_pkg::NUM_THREADS-1:0]                  slot_swap;
  logic [ring_pkg::NUM_THREADS*ring_pkg::DATA_W-1:0] slot_addr;
  logic [ring_pkg::NUM_THREADS*ring_pkg::MASK_W-1:0] slot_mask;
  logic [ring_pkg::NUM_THREADS*ring_pkg::DATA_W-1:0] slot_wdata;
  logic [ring_pkg::NUM_THREADS*ring_pkg::RC_W-1:0]   slot_rc;
  logic [ring_pkg::NUM_THREADS-1:0]                  ack_vec;
  logic [ring_pkg::TID_W-1:0]                        rsp_thread;
  logic [ring_pkg::DATA_W-1:0]                       rsp_data;
  logic [ring_pkg::RING_W-1:0]                       core_to_mem;
  logic [ring_pkg::RING_W-1:0]                       mem_to_core;

  ring_req_slots #(.NODE_ID(NODE_ID)) u_ring_req_slots (
    .CLK(CLK), .RST(RST), .slice(slice), .req_cs(req_cs), .req_swap(req_swap),
    .req_wr(req_wr), .req_addr(req_addr), .req_mask(req_mask), .req_wdata(req_wdata),
    .req_rc(req_rc), .ack_vec(ack_vec), .stall(stall), .slot_pending(slot_pending),
    .slot_wr(slot_wr), .slot_swap(slot_swap), .slot_addr(slot_addr),
    .slot_mask(slot_mask), .slot_wdata(slot_wdata), .slot_rc(slot_rc)
  );

  // Retries are consumed inside the arbiter
  ring_node_arb #(.NODE_ID(NODE_ID)) u_ring_node_arb (
    .CLK(CLK), .RST(RST), .ring_in(mem_to_core), .slot_pending(slot_pending),
    .slot_wr(slot_wr), .slot_addr(slot_addr), .slot_mask(slot_mask),
    .slot_wdata(slot_wdata), .ring_out(core_to_mem), .ack_vec(ack_vec),
    .retry_vec(), .rsp_thread(rsp_thread), .rsp_data(rsp_data)
  );

  load_format u_load_format (
    .CLK(CLK), .RST(RST), .ack_vec(ack_vec), .rsp_thread(rsp_thread),
    .rsp_data(rsp_data), .slot_wr(slot_wr), .slot_swap(slot_swap),
    .slot_mask(slot_mask), .slot_rc(slot_rc), .load_vld(load_vld),
    .load_slice(load_slice), .load_sel(load_sel), .load_data(load_data)
  );

  ring_mem_node #(.MEM_WORDS(MEM_WORDS)) u_ring_mem_node (
    .CLK(CLK), .RST(RST), .ring_in(core_to_mem), .ring_out(mem_to_core)
  );

endmodule

// ==== dv/tb_ring_subsys.sv ====
module tb_ring_subsys;

  localparam int CLK_PER    = 100;
  localparam int DRV_DLY    = 10;
  localparam int RST_CYCLES = 8;
  localparam int WAIT_LIMIT = 200;
  localparam int MAX_OPS    = 64;
  localparam int COLS       = 7;

  // Op codes in the first column of the vector file
  localparam logic [31:0] OP_WRITE = 32'h1;
  localparam logic [31:0] OP_DRAIN = 32'h3;
  localparam logic [31:0] OP_END   = 32'hf;

  logic        CLK;
  logic        RST;
  logic [1:0]  slice;
  logic        req_cs;
  logic        req_swap;
  logic        req_wr;
  logic [31:0] req_addr;
  logic [3:0]  req_mask;
  logic [31:0] req_wdata;
  logic [2:0]  req_rc;
  logic [3:0]  stall;
  logic        load_vld;
  logic [1:0]  load_slice;
  logic [2:0]  load_sel;
  logic [31:0] load_data;

  logic [31:0] vec [MAX_OPS*COLS];

  // The issuing side owns these
  logic [2:0]  exp_sel [4];
  logic [31:0] exp_data [4];
  int          issued_cnt [4] = '{0, 0, 0, 0};
  int          errors = 0;
  bit          timed_out = 1'b0;

  // The load monitor owns these
  int          done_cnt [4] = '{0, 0, 0, 0};
  int          mon_errors = 0;
  int          checks = 0;
  int          max_busy = 0;

  ring_subsys_top u_ring_subsys_top (
    .CLK(CLK), .RST(RST), .slice(slice), .req_cs(req_cs), .req_swap(req_swap),
    .req_wr(req_wr), .req_addr(req_addr), .req_mask(req_mask), .req_wdata(req_wdata),
    .req_rc(req_rc), .stall(stall), .load_vld(load_vld), .load_slice(load_slice),
    .load_sel(load_sel), .load_data(load_data)
  );

  always #(CLK_PER/2) CLK = ~CLK;

  // Every input change goes through here, and the issue slice rotates once per cycle
  task automatic next_cycle();
    @(posedge CLK);
    #DRV_DLY;
    slice = slice + 1'b1;
  endtask

  task automatic drain_all();
    int n;
    n = 0;
    while (stall != '0 && n < WAIT_LIMIT)
    begin
      next_cycle();
      n++;
    end
    if (n >= WAIT_LIMIT)
    begin
      timed_out = 1'b1;
      errors++;
      $display("Timed out at %0t waiting for all threads to go idle, stall=%h", $time, stall);
    end
  endtask

  task automatic issue_op(input int b);
    logic [1:0] op_slice;
    logic [1:0] thr;
    int         n;
    op_slice = vec[b+1][1:0];
    // Issue runs two slices ahead of the owning thread
    thr = op_slice + 2'd2;
    n = 0;
    while ((slice != op_slice || stall[thr]) && n < WAIT_LIMIT)
    begin
      next_cycle();
      n++;
    end
    if (n >= WAIT_LIMIT)
    begin
      timed_out = 1'b1;
      errors++;
      $display("Timed out at %0t waiting to issue op %0d on thread %0d", $time, b/COLS, thr);
    end
    else
    begin
      req_cs    = 1'b1;
      req_wr    = (vec[b] == OP_WRITE);
      req_swap  = (vec[b] == 32'h2);
      req_addr  = vec[b+2];
      req_mask  = vec[b+3][3:0];
      req_wdata = vec[b+4];
      req_rc    = vec[b+5][2:0];
      next_cycle();
      req_cs = 1'b0;
      // Recorded only after capture so a load finishing in the issue cycle sees the old entry
      if (vec[b] != OP_WRITE)
      begin
        exp_sel[thr]  = vec[b+5][2:0];
        exp_data[thr] = vec[b+6];
        issued_cnt[thr]++;
      end
    end
  endtask

  task automatic check_load();
    checks++;
    if (issued_cnt[load_slice] == done_cnt[load_slice])
    begin
      mon_errors++;
      $display("Unexpected load_vld at %0t on thread %0d with no read outstanding",
               $time, load_slice);
    end
    else
    begin
      if (load_sel !== exp_sel[load_slice])
      begin
        mon_errors++;
        $display("[ERROR] %0t load_sel thread %0d: got %0d, expected %0d",
                 $time, load_slice, load_sel, exp_sel[load_slice]);
      end
      if (load_data !== exp_data[load_slice])
      begin
        mon_errors++;
        $display("[ERROR] %0t load_data thread %0d: got %h, expected %h",
                 $time, load_slice, load_data, exp_data[load_slice]);
      end
      done_cnt[load_slice]++;
    end
  endtask

  // Outputs are looked at on the falling edge where they have settled
  always @(negedge CLK)
  begin
    if (!RST)
    begin
      if ($countones(stall) > max_busy)
        max_busy = $countones(stall);
      if (load_vld)
        check_load();
    end
  end

  initial
  begin
    int b;
    int t;
    CLK       = 1'b0;
    RST       = 1'b1;
    slice     = '0;
    req_cs    = 1'b0;
    req_swap  = 1'b0;
    req_wr    = 1'b0;
    req_addr  = '0;
    req_mask  = '0;
    req_wdata = '0;
    req_rc    = '0;
    $readmemh("dv/ring_input_vectors.txt", vec);

    for (t = 0; t < RST_CYCLES; t++)
      next_cycle();
    RST = 1'b0;
    next_cycle();
    if (stall !== 4'h0)
    begin
      errors++;
      $display("[ERROR] %0t stall after reset: got %h, expected 0", $time, stall);
    end

    b = 0;
    while (!timed_out && b < MAX_OPS*COLS && vec[b] != OP_END)
    begin
      if (vec[b] == OP_DRAIN)
        drain_all();
      else
        issue_op(b);
      b += COLS;
    end

    if (!timed_out)
    begin
      drain_all();
      next_cycle();
      next_cycle();
    end
    for (t = 0; t < 4; t++)
    begin
      if (issued_cnt[t] != done_cnt[t])
      begin
        errors++;
        $display("Thread %0d finished with %0d of %0d reads completed",
                 t, done_cnt[t], issued_cnt[t]);
      end
    end
    if (max_busy != 4)
    begin
      errors++;
      $display("Never had all four threads outstanding, at most %0d", max_busy);
    end

    $display("Load checks: %0d, errors: %0d", checks, errors + mon_errors);
    if (errors + mon_errors == 0)
      $display("PASS: all tests");
    else
      $display("FAIL: see errors above");
    $finish;
  end

endmodule

// ==== dv/ring_input_vectors.txt ====
// op slice addr mask wdata rc expected_load, all hex
// op 0 read, 1 write, 2 swap, 3 wait for all threads idle, f end of list
1 0 00000010 f 12345678 0 00000000
0 0 00000010 f 00000000 5 12345678
1 1 00000020 f a1b2c3d4 0 00000000
1 1 00000020 4 00ee0000 0 00000000
0 1 00000020 4 00000000 1 000000ee
0 1 00000020 1 00000000 2 000000d4
0 1 00000020 c 00000000 3 0000a1ee
0 1 00000020 3 00000000 4 0000c3d4
0 1 00000020 8 00000000 6 000000a1
2 2 00000030 f cafef00d 7 00000000
2 2 00000030 3 00001234 1 0000f00d
0 2 00000030 f 00000000 2 cafe1234
3 0 00000000 0 00000000 0 00000000
0 0 00000010 f 00000000 1 12345678
0 1 00000020 f 00000000 2 a1eec3d4
0 2 00000030 f 00000000 3 cafe1234
0 3 00000040 f 00000000 4 00000000
3 0 00000000 0 00000000 0 00000000
1 0 00000050 f 11111111 0 00000000
1 1 00000054 f 22222222 0 00000000
1 2 00000058 f 33333333 0 00000000
1 3 0000005c 6 44444444 0 00000000
3 0 00000000 0 00000000 0 00000000
0 0 00000050 f 00000000 1 11111111
0 1 00000054 f 00000000 2 22222222
0 2 00000058 f 00000000 3 33333333
0 3 0000005c f 00000000 4 00444400
0 1 00000110 f 00000000 5 12345678
f 0 00000000 0 00000000 0 00000000

// ==== verilog.f ====
src/ring_pkg.sv
src/ring_req_slots.sv
src/ring_node_arb.sv
src/load_format.sv
src/ring_mem_node.sv
src/ring_subsys_top.sv
dv/tb_ring_subsys.sv

// ==== Makefile ====
TOP := tb_ring_subsys

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module $(TOP) -f verilog.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f verilog.f -Mdir obj_dir
	out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "PASS: all tests"

clean:
	rm -rf obj_dir
